// ==== verilog/fm_spy_settings.svh ====
`ifndef FM_SPY_SETTINGS_SVH
`define FM_SPY_SETTINGS_SVH

// Number of spy buffers in the bank.
`define FM_SB_N 4

// Log2 of the words held by each spy memory.
`define FM_DEPTH_LOG2 6

// Spy data and AXI word width.
`define FM_DATA_W 32

// AXI4-Lite address width.
`define FM_ADDR_W 12

// Saturating capture counter width.
`define FM_COUNT_W 16

// Address map fields.
`define FM_REGION_BIT 11
`define FM_BUF_LSB 9
`define FM_SB_IDX_W 2
`define FM_WORD_LSB 2

// AXI response codes.
`define FM_RESP_OKAY 2'b00
`define FM_RESP_SLVERR 2'b10

`endif

// ==== verilog/fm_spy_pkg.sv ====
`include "fm_spy_settings.svh"

package fm_spy_pkg;

   // Host operation classes.
   // A metadata write is the only access that decodes to op_bad.
   typedef enum logic [1:0]
   {
      op_mem_rd  = 2'd0,
      op_mem_wr  = 2'd1,
      op_meta_rd = 2'd2,
      op_bad     = 2'd3
   } fm_op_e;

   // Decode FSM states.
   typedef enum logic
   {
      st_idle = 1'b0,
      st_busy = 1'b1
   } fm_dec_state_e;

   // One monitored channel.
   typedef struct packed
   {
      logic                  valid;
      logic [`FM_DATA_W-1:0] data;
   } fm_mon_t;

   // Decoded host request, valid for one cycle.
   typedef struct packed
   {
      logic                      valid;
      fm_op_e                    op;
      logic [`FM_SB_IDX_W-1:0]   sb_idx;
      logic [`FM_DEPTH_LOG2-1:0] word_idx;
      logic [`FM_DATA_W-1:0]     wdata;
   } fm_req_t;

   // Executed result. wr_kind routes it to the B channel, else the R channel.
   typedef struct packed
   {
      logic                  valid;
      logic                  wr_kind;
      logic [1:0]            resp;
      logic [`FM_DATA_W-1:0] rdata;
   } fm_rsp_t;

endpackage

// ==== verilog/fm_axi_decode.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_axi_decode
(
   input  logic                    spy_clock,
   input  logic                    axi_reset,
   input  logic [`FM_ADDR_W-1:0]   s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  logic [`FM_DATA_W-1:0]   s_wdata_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   input  logic [`FM_ADDR_W-1:0]   s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   input  logic                    done_i,
   output fm_spy_pkg::fm_req_t     req_o
);

   fm_spy_pkg::fm_dec_state_e state_q;
   logic                      aw_ready_q;
   logic                      ar_ready_q;
   logic                      wr_xfer;
   logic                      rd_xfer;
   logic [`FM_ADDR_W-1:0]     addr_sel;

   logic                      req_valid_q;
   fm_spy_pkg::fm_op_e        op_q;
   logic [`FM_SB_IDX_W-1:0]   sb_idx_q;
   logic [`FM_DEPTH_LOG2-1:0] word_idx_q;
   logic [`FM_DATA_W-1:0]     wdata_q;

   // AW and W are always accepted together.
   assign s_awready_o = aw_ready_q;
   assign s_wready_o  = aw_ready_q;
   assign s_arready_o = ar_ready_q;

   assign wr_xfer  = aw_ready_q && s_awvalid_i && s_wvalid_i;
   assign rd_xfer  = ar_ready_q && s_arvalid_i;
   assign addr_sel = wr_xfer ? s_awaddr_i : s_araddr_i;

   // Acceptance FSM. One transaction at a time.
   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         state_q     <= fm_spy_pkg::st_idle;
         aw_ready_q  <= 1'b0;
         ar_ready_q  <= 1'b0;
         req_valid_q <= 1'b0;
      end
      else
      begin
         req_valid_q <= 1'b0;
         case (state_q)
            fm_spy_pkg::st_idle:
            begin
               if (wr_xfer || rd_xfer)
               begin
                  aw_ready_q  <= 1'b0;
                  ar_ready_q  <= 1'b0;
                  req_valid_q <= 1'b1;
                  state_q     <= fm_spy_pkg::st_busy;
               end
               else if (!aw_ready_q && !ar_ready_q)
               begin
                  // A pending write wins over a pending read.
                  if (s_awvalid_i && s_wvalid_i)
                  begin
                     aw_ready_q <= 1'b1;
                  end
                  else if (s_arvalid_i)
                  begin
                     ar_ready_q <= 1'b1;
                  end
               end
            end
            fm_spy_pkg::st_busy:
            begin
               // Wait for the response handshake.
               if (done_i)
               begin
                  state_q <= fm_spy_pkg::st_idle;
               end
            end
            default:
            begin
               state_q <= fm_spy_pkg::st_idle;
            end
         endcase
      end
   end

   // Address split and op classification.
   always_ff @(posedge spy_clock)
   begin
      if (wr_xfer || rd_xfer)
      begin
         sb_idx_q   <= addr_sel[`FM_BUF_LSB +: `FM_SB_IDX_W];
         word_idx_q <= addr_sel[`FM_WORD_LSB +: `FM_DEPTH_LOG2];
         if (wr_xfer)
         begin
            wdata_q <= s_wdata_i;
            op_q    <= addr_sel[`FM_REGION_BIT] ? fm_spy_pkg::op_bad : fm_spy_pkg::op_mem_wr;
         end
         else
         begin
            op_q <= addr_sel[`FM_REGION_BIT] ? fm_spy_pkg::op_meta_rd : fm_spy_pkg::op_mem_rd;
         end
      end
   end

   assign req_o.valid    = req_valid_q;
   assign req_o.op       = op_q;
   assign req_o.sb_idx   = sb_idx_q;
   assign req_o.word_idx = word_idx_q;
   assign req_o.wdata    = wdata_q;

endmodule

// ==== verilog/fm_spy_bank.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_spy_bank
(
   input  logic                 spy_clock,
   input  logic                 axi_reset,
   input  logic [`FM_SB_N-1:0]  freeze_i,
   input  fm_spy_pkg::fm_mon_t  mon_i [`FM_SB_N],
   input  fm_spy_pkg::fm_req_t  req_i,
   output fm_spy_pkg::fm_rsp_t  rsp_o
);

   localparam int DEPTH = 2 ** `FM_DEPTH_LOG2;

   logic [`FM_DATA_W-1:0]     mem_rd_w [`FM_SB_N];
   logic [`FM_DEPTH_LOG2-1:0] wr_ptr_q [`FM_SB_N];
   logic [`FM_COUNT_W-1:0]    count_q  [`FM_SB_N];

   logic [`FM_DATA_W-1:0]     rd_data_w;
   logic [1:0]                resp_w;
   logic                      wr_kind_w;

   logic                      rsp_valid_q;
   logic                      rsp_wr_kind_q;
   logic [1:0]                rsp_resp_q;
   logic [`FM_DATA_W-1:0]     rsp_rdata_q;

   for (genvar g = 0; g < `FM_SB_N; g++)
   begin : g_buf
      logic [`FM_DATA_W-1:0] mem [DEPTH];
      logic                  cap_en;
      logic                  host_wr;

      assign cap_en  = !freeze_i[g] && mon_i[g].valid;
      // Host writes land only while the buffer is frozen.
      assign host_wr = req_i.valid && (req_i.op == fm_spy_pkg::op_mem_wr) &&
                       (req_i.sb_idx == `FM_SB_IDX_W'(g)) && freeze_i[g];

      // Capture and host write never coincide on one buffer.
      always_ff @(posedge spy_clock)
      begin
         if (cap_en)
         begin
            mem[wr_ptr_q[g]] <= mon_i[g].data;
         end
         else if (host_wr)
         begin
            mem[req_i.word_idx] <= req_i.wdata;
         end
      end

      assign mem_rd_w[g] = mem[req_i.word_idx];

      always_ff @(posedge spy_clock)
      begin
         if (axi_reset)
         begin
            wr_ptr_q[g] <= '0;
            count_q[g]  <= '0;
         end
         else if (cap_en)
         begin
            wr_ptr_q[g] <= wr_ptr_q[g] + 1'b1;
            if (count_q[g] != '1)
            begin
               count_q[g] <= count_q[g] + 1'b1;
            end
         end
      end
   end

   // Result selection for the current request.
   always_comb
   begin
      rd_data_w = '0;
      resp_w    = `FM_RESP_OKAY;
      wr_kind_w = 1'b0;
      case (req_i.op)
         fm_spy_pkg::op_mem_rd:
         begin
            rd_data_w = mem_rd_w[req_i.sb_idx];
         end
         fm_spy_pkg::op_meta_rd:
         begin
            if (req_i.word_idx == 'd0)
            begin
               rd_data_w = {{(`FM_DATA_W-`FM_DEPTH_LOG2){1'b0}}, wr_ptr_q[req_i.sb_idx]};
            end
            else if (req_i.word_idx == 'd1)
            begin
               rd_data_w = {{(`FM_DATA_W-`FM_COUNT_W){1'b0}}, count_q[req_i.sb_idx]};
            end
         end
         fm_spy_pkg::op_mem_wr:
         begin
            wr_kind_w = 1'b1;
            resp_w    = freeze_i[req_i.sb_idx] ? `FM_RESP_OKAY : `FM_RESP_SLVERR;
         end
         default:
         begin
            wr_kind_w = 1'b1;
            resp_w    = `FM_RESP_SLVERR;
         end
      endcase
   end

   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= req_i.valid;
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (req_i.valid)
      begin
         rsp_wr_kind_q <= wr_kind_w;
         rsp_resp_q    <= resp_w;
         rsp_rdata_q   <= rd_data_w;
      end
   end

   assign rsp_o.valid   = rsp_valid_q;
   assign rsp_o.wr_kind = rsp_wr_kind_q;
   assign rsp_o.resp    = rsp_resp_q;
   assign rsp_o.rdata   = rsp_rdata_q;

endmodule

// ==== verilog/fm_axi_result.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_axi_result
(
   input  logic                  spy_clock,
   input  logic                  axi_reset,
   input  fm_spy_pkg::fm_rsp_t   rsp_i,
   output logic [1:0]            s_bresp_o,
   output logic                  s_bvalid_o,
   input  logic                  s_bready_i,
   output logic [`FM_DATA_W-1:0] s_rdata_o,
   output logic [1:0]            s_rresp_o,
   output logic                  s_rvalid_o,
   input  logic                  s_rready_i,
   output logic                  done_o
);

   logic                  bvalid_q;
   logic                  rvalid_q;
   logic                  done_q;
   logic [1:0]            bresp_q;
   logic [1:0]            rresp_q;
   logic [`FM_DATA_W-1:0] rdata_q;

   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
         done_q   <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         if (rsp_i.valid)
         begin
            bvalid_q <= rsp_i.wr_kind;
            rvalid_q <= !rsp_i.wr_kind;
         end
         // Hold until the master takes it.
         if (bvalid_q && s_bready_i)
         begin
            bvalid_q <= 1'b0;
            done_q   <= 1'b1;
         end
         if (rvalid_q && s_rready_i)
         begin
            rvalid_q <= 1'b0;
            done_q   <= 1'b1;
         end
      end
   end

   // Payload loads only on a new result, so it is stable under back-pressure.
   always_ff @(posedge spy_clock)
   begin
      if (rsp_i.valid)
      begin
         if (rsp_i.wr_kind)
         begin
            bresp_q <= rsp_i.resp;
         end
         else
         begin
            rresp_q <= rsp_i.resp;
            rdata_q <= rsp_i.rdata;
         end
      end
   end

   assign s_bvalid_o = bvalid_q;
   assign s_bresp_o  = bresp_q;
   assign s_rvalid_o = rvalid_q;
   assign s_rresp_o  = rresp_q;
   assign s_rdata_o  = rdata_q;
   assign done_o     = done_q;

endmodule

// ==== verilog/fm_spy_top.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_spy_top
(
   input  logic                  spy_clock,
   input  logic                  axi_reset,
   input  logic [`FM_SB_N-1:0]   freeze_i,
   input  fm_spy_pkg::fm_mon_t   mon_i [`FM_SB_N],

   input  logic [`FM_ADDR_W-1:0] s_awaddr_i,
   input  logic                  s_awvalid_i,
   output logic                  s_awready_o,
   input  logic [`FM_DATA_W-1:0] s_wdata_i,
   input  logic                  s_wvalid_i,
   output logic                  s_wready_o,
   output logic [1:0]            s_bresp_o,
   output logic                  s_bvalid_o,
   input  logic                  s_bready_i,

   input  logic [`FM_ADDR_W-1:0] s_araddr_i,
   input  logic                  s_arvalid_i,
   output logic                  s_arready_o,
   output logic [`FM_DATA_W-1:0] s_rdata_o,
   output logic [1:0]            s_rresp_o,
   output logic                  s_rvalid_o,
   input  logic                  s_rready_i
);

   fm_spy_pkg::fm_req_t req;
   fm_spy_pkg::fm_rsp_t rsp;
   logic                done;

   // Address acceptance and op decode.
   fm_axi_decode i_fm_axi_decode
   (
      .spy_clock   (spy_clock),
      .axi_reset   (axi_reset),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .done_i      (done),
      .req_o       (req)
   );

   // Spy memories and capture.
   fm_spy_bank i_fm_spy_bank
   (
      .spy_clock (spy_clock),
      .axi_reset (axi_reset),
      .freeze_i  (freeze_i),
      .mon_i     (mon_i),
      .req_i     (req),
      .rsp_o     (rsp)
   );

   // B and R channels.
   fm_axi_result i_fm_axi_result
   (
      .spy_clock  (spy_clock),
      .axi_reset  (axi_reset),
      .rsp_i      (rsp),
      .s_bresp_o  (s_bresp_o),
      .s_bvalid_o (s_bvalid_o),
      .s_bready_i (s_bready_i),
      .s_rdata_o  (s_rdata_o),
      .s_rresp_o  (s_rresp_o),
      .s_rvalid_o (s_rvalid_o),
      .s_rready_i (s_rready_i),
      .done_o     (done)
   );

endmodule

// ==== verification/fm_spy_chk.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_spy_chk
(
   input logic                  spy_clock,
   input logic                  axi_reset,
   input logic                  s_bvalid_o,
   input logic                  s_bready_i,
   input logic                  s_rvalid_o,
   input logic                  s_rready_i,
   input logic [`FM_DATA_W-1:0] s_rdata_o
);

   // A stalled write response stays up.
   a_bvalid_hold: assert property (@(posedge spy_clock) disable iff (axi_reset)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o)
      else $error("bvalid dropped before bready");

   // Read data frozen while stalled.
   a_rdata_stable: assert property (@(posedge spy_clock) disable iff (axi_reset)
      s_rvalid_o && !s_rready_i |=> $stable(s_rdata_o))
      else $error("rdata changed while stalled");

   a_one_channel: assert property (@(posedge spy_clock) disable iff (axi_reset)
      !(s_bvalid_o && s_rvalid_o))
      else $error("bvalid and rvalid high together");

   a_reset_idle: assert property (@(posedge spy_clock)
      axi_reset |=> !s_bvalid_o && !s_rvalid_o)
      else $error("valid high after reset");

endmodule

bind fm_axi_result fm_spy_chk i_fm_spy_chk
(
   .spy_clock  (spy_clock),
   .axi_reset  (axi_reset),
   .s_bvalid_o (s_bvalid_o),
   .s_bready_i (s_bready_i),
   .s_rvalid_o (s_rvalid_o),
   .s_rready_i (s_rready_i),
   .s_rdata_o  (s_rdata_o)
);

// ==== verification/fm_spy_tb.sv ====
`timescale 1ns/1ps
`include "fm_spy_settings.svh"

module fm_spy_tb;

   localparam int SB_N    = `FM_SB_N;
   localparam int DEPTH   = 2 ** `FM_DEPTH_LOG2;
   localparam int TIMEOUT = 200;

   logic                  spy_clock;
   logic                  axi_reset;
   logic [SB_N-1:0]       freeze;
   fm_spy_pkg::fm_mon_t   mon [SB_N];
   logic [`FM_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [`FM_DATA_W-1:0] wdata;
   logic                  wvalid;
   logic                  wready;
   logic [1:0]            bresp;
   logic                  bvalid;
   logic                  bready;
   logic [`FM_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic [`FM_DATA_W-1:0] rdata;
   logic [1:0]            rresp;
   logic                  rvalid;
   logic                  rready;

   integer                seed;
   int                    errors;
   int                    issued;
   int                    responses;
   logic [SB_N-1:0]       cap_en;
   logic [34:0]           exp_q [$];
   logic [34:0]           exp_e;

   // Reference memories, write pointers and counts.
   logic [`FM_DATA_W-1:0]     model_mem [SB_N][DEPTH];
   logic [`FM_DEPTH_LOG2-1:0] model_ptr [SB_N];
   logic [`FM_COUNT_W-1:0]    model_cnt [SB_N];

   fm_spy_top i_fm_spy_top
   (
      .spy_clock   (spy_clock),
      .axi_reset   (axi_reset),
      .freeze_i    (freeze),
      .mon_i       (mon),
      .s_awaddr_i  (awaddr),
      .s_awvalid_i (awvalid),
      .s_awready_o (awready),
      .s_wdata_i   (wdata),
      .s_wvalid_i  (wvalid),
      .s_wready_o  (wready),
      .s_bresp_o   (bresp),
      .s_bvalid_o  (bvalid),
      .s_bready_i  (bready),
      .s_araddr_i  (araddr),
      .s_arvalid_i (arvalid),
      .s_arready_o (arready),
      .s_rdata_o   (rdata),
      .s_rresp_o   (rresp),
      .s_rvalid_o  (rvalid),
      .s_rready_i  (rready)
   );

   always #50 spy_clock = ~spy_clock;

   function automatic logic [`FM_ADDR_W-1:0] make_addr(input logic region, input int b,
                                                       input int w);
      logic [1:0] bi;
      logic [5:0] wi;
      bi = b[1:0];
      wi = w[5:0];
      return {region, bi, 1'b0, wi, 2'b00};
   endfunction

   // Expected {resp, data} of an access, derived from the address map.
   function automatic logic [33:0] ref_result(input logic [`FM_ADDR_W-1:0] addr, input logic is_wr);
      logic       region;
      logic [1:0] b;
      logic [5:0] w;
      region = addr[11];
      b      = addr[10:9];
      w      = addr[7:2];
      if (is_wr)
      begin
         if (!region && freeze[b])
            return {2'b00, 32'h0};
         return {2'b10, 32'h0};
      end
      if (!region)
         return {2'b00, model_mem[b][w]};
      if (w == 6'd0)
         return {2'b00, 26'h0, model_ptr[b]};
      if (w == 6'd1)
         return {2'b00, 16'h0, model_cnt[b]};
      return {2'b00, 32'h0};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout at %0t: %s", $time, what);
      $display("tests failed");
      $finish;
   endtask

   // Waits for the response and may keep ready low for a random stretch first.
   task automatic take_response(input logic is_wr, input logic stall);
      integer r;
      int     n;
      int     cnt;
      logic   seen;
      r = $random(seed);
      n = stall ? int'(r[2:0]) : 0;
      repeat (n) @(negedge spy_clock);
      @(negedge spy_clock);
      if (is_wr)
         bready = 1'b1;
      else
         rready = 1'b1;
      seen = 1'b0;
      cnt  = 0;
      while (!seen)
      begin
         @(posedge spy_clock);
         if (is_wr ? bvalid : rvalid)
            seen = 1'b1;
         else
         begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
               timeout_fail("no response from the DUT");
         end
      end
      @(negedge spy_clock);
      bready = 1'b0;
      rready = 1'b0;
   endtask

   task automatic axi_read(input logic [`FM_ADDR_W-1:0] addr, input logic stall);
      int   cnt;
      logic seen;
      exp_q.push_back({1'b0, ref_result(addr, 1'b0)});
      issued++;
      @(negedge spy_clock);
      araddr  = addr;
      arvalid = 1'b1;
      seen    = 1'b0;
      cnt     = 0;
      while (!seen)
      begin
         @(posedge spy_clock);
         if (arready)
            seen = 1'b1;
         else
         begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
               timeout_fail("read address was never accepted");
         end
      end
      @(negedge spy_clock);
      arvalid = 1'b0;
      take_response(1'b0, stall);
   endtask

   task automatic axi_write(input logic [`FM_ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic stall);
      int          cnt;
      logic        seen;
      logic [33:0] e;
      e = ref_result(addr, 1'b1);
      // A write that is accepted also lands in the model memory.
      if (e[33:32] == 2'b00)
         model_mem[addr[10:9]][addr[7:2]] = data;
      exp_q.push_back({1'b1, e});
      issued++;
      @(negedge spy_clock);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      seen    = 1'b0;
      cnt     = 0;
      while (!seen)
      begin
         @(posedge spy_clock);
         if (awready && wready)
            seen = 1'b1;
         else
         begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
               timeout_fail("write address and data were never accepted");
         end
      end
      @(negedge spy_clock);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      take_response(1'b1, stall);
   endtask

   // Reference capture on the same edge as the DUT.
   always @(posedge spy_clock)
   begin
      for (int b = 0; b < SB_N; b++)
      begin
         if (axi_reset)
         begin
            model_ptr[b] = '0;
            model_cnt[b] = '0;
         end
         else if (!freeze[b] && mon[b].valid)
         begin
            model_mem[b][model_ptr[b]] = mon[b].data;
            model_ptr[b]               = model_ptr[b] + 1'b1;
            if (model_cnt[b] != '1)
               model_cnt[b] = model_cnt[b] + 1'b1;
         end
      end
   end

   // Monitor stimulus with about three valid words in four.
   always @(negedge spy_clock)
   begin
      for (int b = 0; b < SB_N; b++)
      begin
         mon[b].data  = $random(seed);
         mon[b].valid = cap_en[b] && (($random(seed) & 3) != 0);
      end
   end

   // Response comparison.
   always @(posedge spy_clock)
   begin
      if (!axi_reset && ((rvalid && rready) || (bvalid && bready)))
      begin
         responses++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("error at %0t: response arrived with none outstanding", $time);
         end
         else
         begin
            exp_e = exp_q.pop_front();
            if (rvalid && rready)
            begin
               check("response kind", 32'(exp_e[34]), 32'(1'b0));
               check("s_rresp_o", 32'(rresp), 32'(exp_e[33:32]));
               check("s_rdata_o", rdata, exp_e[31:0]);
            end
            else
            begin
               check("response kind", 32'(exp_e[34]), 32'(1'b1));
               check("s_bresp_o", 32'(bresp), 32'(exp_e[33:32]));
            end
         end
      end
   end

   initial
   begin
      integer r;
      seed      = 68;
      errors    = 0;
      issued    = 0;
      responses = 0;
      spy_clock = 1'b0;
      axi_reset = 1'b1;
      freeze    = '1;
      cap_en    = '0;
      for (int b = 0; b < SB_N; b++)
         mon[b] = '0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (3) @(negedge spy_clock);
      axi_reset = 1'b0;

      // Metadata is zero after reset.
      for (int b = 0; b < SB_N; b++)
      begin
         axi_read(make_addr(1'b1, b, 0), 1'b0);
         axi_read(make_addr(1'b1, b, 1), 1'b0);
      end

      // Stream past the depth, then freeze and read everything back.
      freeze = '0;
      cap_en = '1;
      repeat (150) @(negedge spy_clock);
      freeze = '1;
      cap_en = '0;
      for (int b = 0; b < SB_N; b++)
      begin
         for (int w = 0; w < DEPTH; w++)
            axi_read(make_addr(1'b0, b, w), 1'b0);
         for (int w = 0; w < 3; w++)
            axi_read(make_addr(1'b1, b, w), 1'b0);
      end

      // Host writes to frozen and unfrozen buffers, and to metadata.
      axi_write(make_addr(1'b0, 1, 5), 32'hcafe_0001, 1'b0);
      axi_read(make_addr(1'b0, 1, 5), 1'b0);
      @(negedge spy_clock);
      freeze[2] = 1'b0;
      axi_write(make_addr(1'b0, 2, 7), 32'hdead_0002, 1'b0);
      axi_read(make_addr(1'b0, 2, 7), 1'b0);
      axi_write(make_addr(1'b1, 0, 0), 32'h1234_5678, 1'b0);
      @(negedge spy_clock);
      freeze[2] = 1'b1;

      // Back-pressure with capture running on buffers 2 and 3.
      freeze = 4'b0011;
      cap_en = 4'b1100;
      for (int i = 0; i < 40; i++)
      begin
         r = $random(seed);
         if (r[8])
            axi_write(make_addr(1'b0, int'(r[0]), int'(r[6:1])), $random(seed), 1'b1);
         else
            axi_read(make_addr(1'b0, int'(r[0]), int'(r[6:1])), 1'b1);
      end
      freeze = '1;
      cap_en = '0;
      @(negedge spy_clock);
      for (int b = 0; b < SB_N; b++)
      begin
         axi_read(make_addr(1'b1, b, 0), 1'b1);
         axi_read(make_addr(1'b1, b, 1), 1'b1);
      end
      for (int b = 2; b < SB_N; b++)
         for (int w = 0; w < DEPTH; w++)
            axi_read(make_addr(1'b0, b, w), 1'b1);

      repeat (2) @(negedge spy_clock);
      if (responses != issued)
      begin
         errors++;
         $display("error: %0d responses seen for %0d requests", responses, issued);
      end
      $display("errors: %0d, responses: %0d of %0d", errors, responses, issued);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/fm_spy_pkg.sv
verilog/fm_axi_decode.sv
verilog/fm_spy_bank.sv
verilog/fm_axi_result.sv
verilog/fm_spy_top.sv
verification/fm_spy_chk.sv
verification/fm_spy_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fm_spy_tb -f files.f -o fm_spy_sim \
   && ./obj_dir/fm_spy_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
